// ==== design/vlsu_pkg.sv ====
package vlsu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Bytes in one memory word
    localparam int WORD_BYTES = 4;

    // Memory word, used for addresses and data
    typedef logic [31:0] word_t;

    // Byte-write enables of one word
    typedef logic [WORD_BYTES-1:0] byte_en_t;

    // Element count within one register, enough for VLEN up to 256
    typedef logic [5:0] elem_cnt_t;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    // Value is log2 of the element size in bytes
    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } ew_e;

    typedef enum logic [1:0] {
        LSU_IDLE  = 2'd0,
        LSU_FIRST = 2'd1,
        LSU_EXEC  = 2'd2,
        LSU_LAST  = 2'd3
    } lsu_state_e;

endpackage

// ==== design/vlsu_elem_if.sv ====
`timescale 1ns/1ps

interface vlsu_elem_if;

    vlsu_pkg::lsu_state_e state;
    vlsu_pkg::ew_e        ew;
    logic                 unit_stride;
    // Elements finished before this cycle
    vlsu_pkg::elem_cnt_t  total;
    // Elements in this cycle's access
    vlsu_pkg::elem_cnt_t  count;

    modport ctrl (
        output state, output ew, output unit_stride, output total, output count
    );

    modport lane (
        input state, input ew, input unit_stride, input total, input count
    );

endinterface

// ==== design/vlsu_ctrl.sv ====
`timescale 1ns/1ps

module vlsu_ctrl #(
    parameter int VLEN = 64
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                start_i,
    input  vlsu_pkg::ew_e       ew_i,
    input  logic                unit_stride_i,
    input  vlsu_pkg::elem_cnt_t vl_i,
    input  logic [1:0]          base_offset_i,
    output logic                busy_o,
    output logic                done_o,
    vlsu_elem_if.ctrl           elem
);

    vlsu_pkg::lsu_state_e state;
    vlsu_pkg::lsu_state_e next_state;
    vlsu_pkg::elem_cnt_t  total;
    vlsu_pkg::elem_cnt_t  count;
    vlsu_pkg::elem_cnt_t  word_count;
    vlsu_pkg::elem_cnt_t  remaining;
    vlsu_pkg::elem_cnt_t  full_count;
    vlsu_pkg::elem_cnt_t  next_total;
    vlsu_pkg::elem_cnt_t  vlmax;
    vlsu_pkg::elem_cnt_t  vl_eff;
    logic [2:0]           first_bytes;
    logic                 last_access;

    ////////////////////////////////////////////////////////////////////////////
    // Element counting
    ////////////////////////////////////////////////////////////////////////////

    // Never run past the register capacity
    assign vlmax  = vlsu_pkg::elem_cnt_t'((VLEN / 8) >> ew_i);
    assign vl_eff = (vl_i > vlmax) ? vlmax : vl_i;

    assign first_bytes = 3'(vlsu_pkg::WORD_BYTES) - {1'b0, base_offset_i};

    assign full_count = unit_stride_i
                        ? vlsu_pkg::elem_cnt_t'(vlsu_pkg::WORD_BYTES >> ew_i)
                        : vlsu_pkg::elem_cnt_t'(1);

    // First unit-stride word stops at the end of the base word
    assign word_count = (unit_stride_i && state == vlsu_pkg::LSU_FIRST)
                        ? vlsu_pkg::elem_cnt_t'(first_bytes >> ew_i)
                        : full_count;

    // Last access ends at vl
    assign remaining = vl_eff - total;
    assign count     = (word_count > remaining) ? remaining : word_count;

    assign next_total = total + count;

    // A single access finishes in FIRST
    assign last_access = (state == vlsu_pkg::LSU_LAST)
                      || (state == vlsu_pkg::LSU_FIRST && next_total >= vl_eff);

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = vlsu_pkg::LSU_IDLE;
        case (state)
            vlsu_pkg::LSU_IDLE: begin
                if (start_i)
                    next_state = vlsu_pkg::LSU_FIRST;
            end
            vlsu_pkg::LSU_FIRST, vlsu_pkg::LSU_EXEC: begin
                if (last_access)
                    next_state = vlsu_pkg::LSU_IDLE;
                else if (next_total + full_count >= vl_eff)
                    next_state = vlsu_pkg::LSU_LAST;
                else
                    next_state = vlsu_pkg::LSU_EXEC;
            end
            default: begin
                next_state = vlsu_pkg::LSU_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state  <= vlsu_pkg::LSU_IDLE;
            total  <= '0;
            done_o <= 1'b0;
        end else begin
            state  <= next_state;
            total  <= (state == vlsu_pkg::LSU_IDLE) ? '0 : next_total;
            done_o <= last_access;
        end
    end

    assign busy_o = (state != vlsu_pkg::LSU_IDLE);

    assign elem.state       = state;
    assign elem.ew          = ew_i;
    assign elem.unit_stride = unit_stride_i;
    assign elem.total       = total;
    assign elem.count       = count;

endmodule

// ==== design/vlsu_addr_gen.sv ====
`timescale 1ns/1ps

module vlsu_addr_gen (
    input  logic            clk,
    input  logic            reset_n,
    input  vlsu_pkg::word_t base_address_i,
    input  vlsu_pkg::word_t stride_i,
    vlsu_elem_if.lane       elem,
    output vlsu_pkg::word_t address_o
);

    vlsu_pkg::word_t offset;
    vlsu_pkg::word_t step;
    vlsu_pkg::word_t base;

    // Unit stride walks whole words
    assign step = elem.unit_stride ? vlsu_pkg::word_t'(vlsu_pkg::WORD_BYTES) : stride_i;

    assign base = elem.unit_stride ? {base_address_i[31:2], 2'b00} : base_address_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            offset <= '0;
        end else if (elem.state == vlsu_pkg::LSU_IDLE) begin
            offset <= '0;
        end else begin
            offset <= offset + step;
        end
    end

    assign address_o = base + offset;

endmodule

// ==== design/vlsu_store_lane.sv ====
`timescale 1ns/1ps

module vlsu_store_lane #(
    parameter int VLEN = 64
) (
    input  logic [VLEN-1:0]     write_data_i,
    input  vlsu_pkg::elem_cnt_t vl_i,
    input  vlsu_pkg::word_t     address_i,
    vlsu_elem_if.lane           elem,
    output vlsu_pkg::byte_en_t  byte_en_o,
    output vlsu_pkg::word_t     write_data_o
);

    logic [1:0]          lane_off;
    logic [VLEN-1:0]     shifted;

    // Unit-stride words after the first start at byte 0
    assign lane_off = (elem.unit_stride && elem.state != vlsu_pkg::LSU_FIRST)
                      ? 2'b00
                      : address_i[1:0];

    // Element total moves to bit 0
    assign shifted = write_data_i >> (int'(elem.total) << (int'(elem.ew) + 3));

    always_comb begin
        if (elem.unit_stride) begin
            write_data_o = shifted[31:0] << {lane_off, 3'b000};
        end else begin
            case (elem.ew)
                vlsu_pkg::EW8:  write_data_o = {4{shifted[7:0]}};
                vlsu_pkg::EW16: write_data_o = {2{shifted[15:0]}};
                default:        write_data_o = shifted[31:0];
            endcase
        end
    end

    // Byte b holds element slot (b - lane_off) >> ew of this access
    always_comb begin
        int                  slot;
        vlsu_pkg::elem_cnt_t idx;
        byte_en_o = '0;
        for (int b = 0; b < vlsu_pkg::WORD_BYTES; b++) begin
            slot = (b - int'(lane_off)) >> int'(elem.ew);
            idx  = elem.total + vlsu_pkg::elem_cnt_t'(slot);
            if (b >= int'(lane_off) && slot < int'(elem.count) && idx < vl_i) begin
                byte_en_o[b] = 1'b1;
            end
        end
    end

endmodule

// ==== design/vlsu_load_merge.sv ====
`timescale 1ns/1ps

module vlsu_load_merge #(
    parameter int VLEN = 64
) (
    input  logic            clk,
    input  logic            reset_n,
    input  vlsu_pkg::word_t mem_read_data_i,
    input  vlsu_pkg::word_t address_i,
    vlsu_elem_if.lane       elem,
    output logic [VLEN-1:0] read_data_o
);

    vlsu_pkg::lsu_state_e state_r;
    vlsu_pkg::elem_cnt_t  total_r;
    vlsu_pkg::elem_cnt_t  count_r;
    logic [1:0]           offset_r;
    logic [1:0]           lane_off;
    logic [VLEN-1:0]      result_q;
    logic [VLEN-1:0]      merged;
    logic [VLEN-1:0]      merge_mask;
    logic [VLEN-1:0]      merge_data;

    ////////////////////////////////////////////////////////////////////////////
    // Access in flight
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_r  <= vlsu_pkg::LSU_IDLE;
            total_r  <= '0;
            count_r  <= '0;
            offset_r <= '0;
        end else begin
            state_r  <= elem.state;
            total_r  <= elem.total;
            count_r  <= elem.count;
            offset_r <= address_i[1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Merge of the returned word
    ////////////////////////////////////////////////////////////////////////////

    assign lane_off = (elem.unit_stride && state_r != vlsu_pkg::LSU_FIRST) ? 2'b00 : offset_r;

    always_comb begin
        int              field_bits;
        int              pos;
        vlsu_pkg::word_t aligned;
        vlsu_pkg::word_t word_mask;
        field_bits = int'(count_r) << (int'(elem.ew) + 3);
        pos        = int'(total_r) << (int'(elem.ew) + 3);
        aligned    = mem_read_data_i >> {lane_off, 3'b000};
        word_mask  = (field_bits >= 32) ? '1 : (vlsu_pkg::word_t'(1) << field_bits) - 1'b1;
        // Bits shifted past VLEN fall away
        merge_mask = VLEN'(word_mask) << pos;
        merge_data = VLEN'(aligned & word_mask) << pos;
        if (state_r == vlsu_pkg::LSU_IDLE)
            merged = result_q;
        else
            merged = (result_q & ~merge_mask) | merge_data;
    end

    // New operation starts from zero so tail elements read as zero
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_q <= '0;
        end else if (elem.state == vlsu_pkg::LSU_FIRST && state_r == vlsu_pkg::LSU_IDLE) begin
            result_q <= '0;
        end else begin
            result_q <= merged;
        end
    end

    assign read_data_o = merged;

endmodule

// ==== design/vlsu_top.sv ====
`timescale 1ns/1ps

module vlsu_top #(
    parameter int VLEN = 64
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                start_i,
    input  logic                store_i,
    input  logic                unit_stride_i,
    input  vlsu_pkg::ew_e       ew_i,
    input  vlsu_pkg::elem_cnt_t vl_i,
    input  vlsu_pkg::word_t     base_address_i,
    input  vlsu_pkg::word_t     stride_i,
    input  logic [VLEN-1:0]     write_data_i,
    input  vlsu_pkg::word_t     mem_read_data_i,
    output logic                busy_o,
    output logic                done_o,
    output logic [VLEN-1:0]     read_data_o,
    output vlsu_pkg::word_t     mem_address_o,
    output logic                mem_read_enable_o,
    output vlsu_pkg::byte_en_t  mem_write_enable_o,
    output vlsu_pkg::word_t     mem_write_data_o
);

    vlsu_elem_if elem ();

    vlsu_pkg::word_t    address;
    vlsu_pkg::word_t    lane_address;
    vlsu_pkg::byte_en_t byte_en;
    logic               active;

    vlsu_ctrl #(.VLEN(VLEN)) ctrl0 (
        .clk           (clk),
        .reset_n       (reset_n),
        .start_i       (start_i),
        .ew_i          (ew_i),
        .unit_stride_i (unit_stride_i),
        .vl_i          (vl_i),
        .base_offset_i (base_address_i[1:0]),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .elem          (elem.ctrl)
    );

    vlsu_addr_gen addr_gen0 (
        .clk            (clk),
        .reset_n        (reset_n),
        .base_address_i (base_address_i),
        .stride_i       (stride_i),
        .elem           (elem.lane),
        .address_o      (address)
    );

    // Unit-stride words keep the base byte offset for the first access
    assign lane_address = unit_stride_i ? {address[31:2], base_address_i[1:0]} : address;

    vlsu_store_lane #(.VLEN(VLEN)) store_lane0 (
        .write_data_i (write_data_i),
        .vl_i         (vl_i),
        .address_i    (lane_address),
        .elem         (elem.lane),
        .byte_en_o    (byte_en),
        .write_data_o (mem_write_data_o)
    );

    vlsu_load_merge #(.VLEN(VLEN)) load_merge0 (
        .clk             (clk),
        .reset_n         (reset_n),
        .mem_read_data_i (mem_read_data_i),
        .address_i       (lane_address),
        .elem            (elem.lane),
        .read_data_o     (read_data_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory port
    ////////////////////////////////////////////////////////////////////////////

    assign active = (elem.state != vlsu_pkg::LSU_IDLE);

    assign mem_address_o      = address;
    assign mem_read_enable_o  = active && !store_i;
    assign mem_write_enable_o = (active && store_i) ? byte_en : '0;

endmodule

// ==== verif/vlsu_tb.sv ====
`timescale 1ns/1ps

module vlsu_tb;

    localparam int VLEN         = 64;
    localparam int VLEN_BYTES   = VLEN / 8;
    localparam int DONE_TIMEOUT = 40;

    logic                clk = 1'b0;
    logic                reset_n;
    logic                start_i;
    logic                store_i;
    logic                unit_stride_i;
    vlsu_pkg::ew_e       ew_i;
    vlsu_pkg::elem_cnt_t vl_i;
    vlsu_pkg::word_t     base_address_i;
    vlsu_pkg::word_t     stride_i;
    logic [VLEN-1:0]     write_data_i;
    vlsu_pkg::word_t     mem_read_data = '0;
    logic                busy_o;
    logic                done_o;
    logic [VLEN-1:0]     read_data_o;
    vlsu_pkg::word_t     mem_address_o;
    logic                mem_read_enable_o;
    vlsu_pkg::byte_en_t  mem_write_enable_o;
    vlsu_pkg::word_t     mem_write_data_o;

    logic [7:0]      mem [0:255];
    logic [7:0]      exp_mem [0:255];
    logic [VLEN-1:0] exp_data;
    logic            exp_store = 1'b0;
    logic [15:0]     lfsr_q = 16'd85;
    int              errors = 0;
    int              checks = 0;
    int              ops = 0;

    vlsu_top #(.VLEN(VLEN)) dut0 (
        .clk                (clk),
        .reset_n            (reset_n),
        .start_i            (start_i),
        .store_i            (store_i),
        .unit_stride_i      (unit_stride_i),
        .ew_i               (ew_i),
        .vl_i               (vl_i),
        .base_address_i     (base_address_i),
        .stride_i           (stride_i),
        .write_data_i       (write_data_i),
        .mem_read_data_i    (mem_read_data),
        .busy_o             (busy_o),
        .done_o             (done_o),
        .read_data_o        (read_data_o),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    always #20 clk = ~clk;

    // Byte memory, word read returns one cycle after the address
    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (mem_write_enable_o[b])
                mem[{mem_address_o[7:2], 2'(b)}] = mem_write_data_o[8*b +: 8];
        end
        if (mem_read_enable_o)
            mem_read_data <= {mem[{mem_address_o[7:2], 2'd3}], mem[{mem_address_o[7:2], 2'd2}],
                              mem[{mem_address_o[7:2], 2'd1}], mem[{mem_address_o[7:2], 2'd0}]};
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers and reference models
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // Word offset that keeps elements aligned to their size
    function automatic logic [31:0] pick_base(input int ew);
        logic [31:0] base;
        base = rand_bits(8) & 32'hFC;
        if (ew == 0)
            base = base | (1 + rand_bits(2) % 3);
        else if (ew == 1)
            base = base | 32'd2;
        return base;
    endfunction

    function automatic logic [VLEN-1:0] load_ref(input int ew, input bit unit, input int vl,
                                                 input logic [31:0] base,
                                                 input logic [31:0] stride);
        logic [VLEN-1:0] r;
        int              esz;
        int              filled;
        logic [31:0]     addr;
        esz    = 1 << ew;
        r      = '0;
        filled = (vl < VLEN_BYTES / esz) ? vl : VLEN_BYTES / esz;
        // Elements at and above vl stay zero
        for (int e = 0; e < filled; e++) begin
            addr = unit ? base + e * esz : base + e * stride;
            for (int b = 0; b < esz; b++)
                r[(e * esz + b) * 8 +: 8] = mem[(addr + b) & 255];
        end
        return r;
    endfunction

    function automatic void store_ref(input int ew, input bit unit, input int vl,
                                      input logic [31:0] base, input logic [31:0] stride,
                                      input logic [VLEN-1:0] wdata);
        int          esz;
        logic [31:0] addr;
        esz = 1 << ew;
        for (int e = 0; e < vl && e < VLEN_BYTES / esz; e++) begin
            addr = unit ? base + e * esz : base + e * stride;
            for (int b = 0; b < esz; b++)
                exp_mem[(addr + b) & 255] = wdata[(e * esz + b) * 8 +: 8];
        end
    endfunction

    task automatic report_value(input string name, input logic [VLEN-1:0] expected,
                                input logic [VLEN-1:0] actual);
        $display("[ERROR] %0t ns %s expected %h got %h", $time, name, expected, actual);
        errors++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Operation driver
    ////////////////////////////////////////////////////////////////////////////

    // Second start pulse lands while the unit is already in FIRST
    task automatic run_op(input bit store, input bit unit, input int ew, input int vl,
                          input logic [31:0] base, input logic [31:0] stride, input bit poke);
        int              cycles;
        logic [VLEN-1:0] wdata;
        @(negedge clk);
        wdata[63:32] = rand_bits(32);
        wdata[31:0]  = rand_bits(32);
        exp_store    = store;
        if (store) begin
            for (int a = 0; a < 256; a++)
                exp_mem[a] = mem[a];
            store_ref(ew, unit, vl, base, stride, wdata);
        end else begin
            exp_data = load_ref(ew, unit, vl, base, stride);
        end
        store_i        = store;
        unit_stride_i  = unit;
        ew_i           = vlsu_pkg::ew_e'(ew);
        vl_i           = vlsu_pkg::elem_cnt_t'(vl);
        base_address_i = base;
        stride_i       = stride;
        write_data_i   = wdata;
        start_i        = 1'b1;
        @(negedge clk);
        start_i = poke;
        if (busy_o !== 1'b1)
            report_value("busy_o", 1, busy_o);
        cycles = 0;
        while (done_o !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            start_i = 1'b0;
            cycles++;
        end
        if (done_o !== 1'b1) begin
            $display("Timed out at %0t ns waiting for done_o", $time);
            errors++;
        end
        ops++;
    endtask

    // Result compare at each done pulse
    always @(negedge clk) begin
        if (done_o === 1'b1) begin
            checks++;
            if (busy_o !== 1'b0)
                report_value("busy_o", 0, busy_o);
            if (exp_store) begin
                for (int a = 0; a < 256; a++) begin
                    if (mem[a] !== exp_mem[a])
                        report_value($sformatf("mem[%0d]", a), exp_mem[a], mem[a]);
                end
            end else if (read_data_o !== exp_data) begin
                report_value("read_data_o", exp_data, read_data_o);
            end
        end
    end

    // Memory port direction follows the running operation
    always @(negedge clk) begin
        if (exp_store && mem_read_enable_o !== 1'b0)
            report_value("mem_read_enable_o", 0, mem_read_enable_o);
        if (!exp_store && mem_write_enable_o !== 4'b0000)
            report_value("mem_write_enable_o", 0, mem_write_enable_o);
    end

    initial begin
        int          ew;
        int          vl;
        int          vlmax;
        logic [31:0] base;
        logic [31:0] stride;
        reset_n        = 1'b0;
        start_i        = 1'b0;
        store_i        = 1'b0;
        unit_stride_i  = 1'b0;
        ew_i           = vlsu_pkg::EW8;
        vl_i           = '0;
        base_address_i = '0;
        stride_i       = '0;
        write_data_i   = '0;
        for (int a = 0; a < 256; a++)
            mem[a] = 8'(rand_bits(8));
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        if (busy_o !== 1'b0)
            report_value("busy_o", 0, busy_o);
        if (done_o !== 1'b0)
            report_value("done_o", 0, done_o);
        if (mem_write_enable_o !== 4'b0000)
            report_value("mem_write_enable_o", 0, mem_write_enable_o);
        if (mem_read_enable_o !== 1'b0)
            report_value("mem_read_enable_o", 0, mem_read_enable_o);
        if (read_data_o !== '0)
            report_value("read_data_o", 0, read_data_o);

        // Aligned full-length word load
        run_op(1'b0, 1'b1, 2, 2, rand_bits(8) & 32'hFC, 32'd0, 1'b0);

        // Misaligned byte and halfword loads
        for (int i = 0; i < 6; i++) begin
            ew    = i % 2;
            vlmax = VLEN_BYTES >> ew;
            vl    = 1 + int'(rand_bits(3) % vlmax);
            run_op(1'b0, 1'b1, ew, vl, pick_base(ew), 32'd0, 1'b0);
        end

        // Partial unit-stride stores at each width
        for (int i = 0; i < 6; i++) begin
            ew    = i % 3;
            vlmax = VLEN_BYTES >> ew;
            vl    = (vlmax > 1) ? 1 + int'(rand_bits(3) % (vlmax - 1)) : 1;
            run_op(1'b1, 1'b1, ew, vl, pick_base(ew), 32'd0, 1'b0);
        end

        // Strided loads, then strided stores
        for (int i = 0; i < 8; i++) begin
            ew     = 1 + i % 2;
            vlmax  = VLEN_BYTES >> ew;
            vl     = 1 + int'(rand_bits(3) % vlmax);
            base   = rand_bits(8) & ~((32'd1 << ew) - 1);
            stride = (32'd1 << ew) * (1 + rand_bits(3));
            run_op(i >= 4, 1'b0, ew, vl, base, stride, 1'b0);
        end

        // Start pulses while busy
        run_op(1'b0, 1'b1, 0, 8, 32'h41, 32'd0, 1'b1);
        run_op(1'b1, 1'b1, 1, 3, 32'h92, 32'd0, 1'b1);

        repeat (2) @(negedge clk);
        if (checks != ops) begin
            $display("Saw %0d done pulses for %0d operations", checks, ops);
            errors++;
        end
        $display("Operations: %0d, compares: %0d, errors: %0d", ops, checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== list.f ====
design/vlsu_pkg.sv
design/vlsu_elem_if.sv
design/vlsu_ctrl.sv
design/vlsu_addr_gen.sv
design/vlsu_store_lane.sv
design/vlsu_load_merge.sv
design/vlsu_top.sv
verif/vlsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vector load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module vlsu_tb -f list.f -o vlsu_sim
./obj_dir/vlsu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1
